// ==== source/sq_pkg.sv ====
/*
   Shared sizes, types and enums of the iterated modular squarer
   Operands are 9 limbs of 17 bits on a 16-bit word grid
*/
package sq_pkg;

   // Limb geometry
   localparam int WORD_LEN           = 16;
   localparam int BIT_LEN            = 17;
   localparam int NONREDUNDANT_LIMBS = 8;
   localparam int REDUNDANT_LIMBS    = 1;
   localparam int NUM_LIMBS          = NONREDUNDANT_LIMBS + REDUNDANT_LIMBS;

   // Two segments where the high one carries the redundant limb
   localparam int SEG_LOW_LIMBS      = 4;
   localparam int SEG_HIGH_LIMBS     = 5;

   // Full square spans 18 columns and those from 8 upward are folded back
   localparam int NUM_COLUMNS        = 18;
   localparam int FOLD_COLUMNS       = 10;
   localparam int LOOKUP_WIDTH       = 8;
   localparam int COL_LEN            = 24;
   localparam int ITER_WIDTH         = 8;

   typedef logic [BIT_LEN-1:0]    limb_t;
   typedef logic [WORD_LEN-1:0]   word_t;
   typedef logic [COL_LEN-1:0]    column_t;
   typedef logic [ITER_WIDTH-1:0] iter_count_t;

   typedef enum logic [2:0] {
      IDLE,
      MUL_LOW,
      MUL_HIGH,
      ACCUMULATE,
      LOOKUP,
      FOLD
   } seq_state_t;

   // Segment pairs a multiplier can be asked for
   typedef enum logic [1:0] {
      PAIR_AA,
      PAIR_AB,
      PAIR_BB,
      PAIR_NONE
   } mul_pair_t;

endpackage

// ==== source/square_sequencer.sv ====
/*
   Square sequencer
   Runs each iteration through five cycles, issues multiplier pairs
   and pipeline strobes, and reports valid and busy
*/
module square_sequencer (
   input  logic                clk,
   input  logic                reset,
   input  logic                start,
   input  sq_pkg::iter_count_t iterations,
   output sq_pkg::mul_pair_t   mul0_pair,
   output sq_pkg::mul_pair_t   mul1_pair,
   output logic                ab_capture,
   output logic                bb_capture,
   output logic                lut_read,
   output logic                fold_load,
   output logic                loop_select,
   output logic                valid,
   output logic                busy
);
   import sq_pkg::*;

   seq_state_t  state;
   iter_count_t remaining;
   logic        accept;

   // Busy stays high through the valid cycle, so start is only seen in IDLE
   assign accept = start && !busy;

   always_ff @(posedge clk) begin
      if (reset) begin
         state       <= IDLE;
         remaining   <= '0;
         loop_select <= 1'b0;
         valid       <= 1'b0;
         busy        <= 1'b0;
      end else begin
         valid <= 1'b0;
         if (accept) begin
            busy <= 1'b1;
         end else if (valid) begin
            busy <= 1'b0;
         end

         case (state)
            IDLE: begin
               if (accept) begin
                  state       <= MUL_LOW;
                  remaining   <= iterations;
                  loop_select <= 1'b0;
               end
            end
            MUL_LOW:    state <= MUL_HIGH;
            MUL_HIGH:   state <= ACCUMULATE;
            ACCUMULATE: state <= LOOKUP;
            LOOKUP:     state <= FOLD;
            FOLD: begin
               // Later iterations square the previous result
               remaining   <= remaining - iter_count_t'(1);
               loop_select <= 1'b1;
               if (remaining == iter_count_t'(1)) begin
                  valid <= 1'b1;
                  state <= IDLE;
               end else begin
                  state <= MUL_LOW;
               end
            end
            default:    state <= IDLE;
         endcase
      end
   end

   // AA and AB go out together, BB follows on multiplier 0
   assign mul0_pair  = (state == MUL_LOW)  ? PAIR_AA :
                       (state == MUL_HIGH) ? PAIR_BB : PAIR_NONE;
   assign mul1_pair  = (state == MUL_LOW)  ? PAIR_AB : PAIR_NONE;
   assign ab_capture = (state == MUL_HIGH);
   assign bb_capture = (state == ACCUMULATE);
   assign lut_read   = (state == LOOKUP);
   assign fold_load  = (state == FOLD);

endmodule

// ==== source/segment_multiplier.sv ====
/*
   Segment multiplier
   Squares or multiplies the operand segments named by the pair code
   and registers the product as 16-bit weighted columns
*/
module segment_multiplier (
   input  logic              clk,
   input  sq_pkg::mul_pair_t pair,
   input  sq_pkg::limb_t     operand [sq_pkg::NUM_LIMBS],
   output sq_pkg::column_t   product [2*sq_pkg::SEG_HIGH_LIMBS]
);
   import sq_pkg::*;

   localparam int SEG_LEN   = SEG_HIGH_LIMBS;
   localparam int PROD_COLS = 2 * SEG_LEN;

   limb_t   seg_low  [SEG_LEN];
   limb_t   seg_high [SEG_LEN];
   limb_t   mul_x    [SEG_LEN];
   limb_t   mul_y    [SEG_LEN];
   column_t col_sum  [PROD_COLS];

   // Segment A is zero padded up to the length of segment B
   always_comb begin
      for (int i = 0; i < SEG_LEN; i++) begin
         seg_low[i]  = (i < SEG_LOW_LIMBS) ? operand[i] : '0;
         seg_high[i] = operand[SEG_LOW_LIMBS + i];
      end
   end

   always_comb begin
      case (pair)
         PAIR_AA: begin
            mul_x = seg_low;
            mul_y = seg_low;
         end
         PAIR_AB: begin
            mul_x = seg_low;
            mul_y = seg_high;
         end
         PAIR_BB: begin
            mul_x = seg_high;
            mul_y = seg_high;
         end
         default: begin
            mul_x = '{default: '0};
            mul_y = '{default: '0};
         end
      endcase
   end

   // Low word of each limb product stays in its column, the rest moves up one
   always_comb begin : column_sum
      logic [2*BIT_LEN-1:0] partial;
      col_sum = '{default: '0};
      for (int i = 0; i < SEG_LEN; i++) begin
         for (int j = 0; j < SEG_LEN; j++) begin
            partial = {{BIT_LEN{1'b0}}, mul_x[i]} * {{BIT_LEN{1'b0}}, mul_y[j]};
            col_sum[i+j]   += column_t'(partial[WORD_LEN-1:0]);
            col_sum[i+j+1] += column_t'(partial[2*BIT_LEN-1:WORD_LEN]);
         end
      end
   end

   always_ff @(posedge clk) begin
      product <= col_sum;
   end

endmodule

// ==== source/column_accumulator.sv ====
/*
   Column accumulator
   Places AA, doubled AB and BB on the column grid, sums each column
   and registers them after one step of partial carry reduction
*/
module column_accumulator (
   input  logic            clk,
   input  sq_pkg::column_t product0 [2*sq_pkg::SEG_HIGH_LIMBS],
   input  sq_pkg::column_t product1 [2*sq_pkg::SEG_HIGH_LIMBS],
   input  logic            ab_capture,
   input  logic            bb_capture,
   output sq_pkg::limb_t   low_columns  [sq_pkg::NONREDUNDANT_LIMBS],
   output sq_pkg::limb_t   fold_columns [sq_pkg::FOLD_COLUMNS]
);
   import sq_pkg::*;

   localparam int PROD_COLS = 2 * SEG_HIGH_LIMBS;
   localparam int AB_OFFSET = SEG_LOW_LIMBS;
   localparam int BB_OFFSET = 2 * SEG_LOW_LIMBS;

   column_t aa_hold [PROD_COLS];
   column_t ab_hold [PROD_COLS];
   column_t grid_sum [NUM_COLUMNS];
   limb_t   reduced [NUM_COLUMNS];

   // AA and AB wait here one cycle for BB
   always_ff @(posedge clk) begin
      if (ab_capture) begin
         aa_hold <= product0;
         ab_hold <= product1;
      end
   end

   always_comb begin
      grid_sum = '{default: '0};
      for (int k = 0; k < PROD_COLS; k++) begin
         grid_sum[k]             += aa_hold[k];
         // Cross product counts twice
         grid_sum[k + AB_OFFSET] += {ab_hold[k][COL_LEN-2:0], 1'b0};
         grid_sum[k + BB_OFFSET] += product0[k];
      end
   end

   // Each column keeps its low word plus the carry bits of its neighbour
   always_comb begin
      reduced[0] = limb_t'(grid_sum[0][WORD_LEN-1:0]);
      for (int c = 1; c < NUM_COLUMNS - 1; c++) begin
         reduced[c] = limb_t'(grid_sum[c][WORD_LEN-1:0]) +
                      limb_t'(grid_sum[c-1][COL_LEN-1:WORD_LEN]);
      end
      reduced[NUM_COLUMNS-1] = grid_sum[NUM_COLUMNS-1][BIT_LEN-1:0] +
                               limb_t'(grid_sum[NUM_COLUMNS-2][COL_LEN-1:WORD_LEN]);
   end

   always_ff @(posedge clk) begin
      if (bb_capture) begin
         for (int c = 0; c < NONREDUNDANT_LIMBS; c++) begin
            low_columns[c] <= reduced[c];
         end
         for (int c = 0; c < FOLD_COLUMNS; c++) begin
            fold_columns[c] <= reduced[NONREDUNDANT_LIMBS + c];
         end
      end
   end

endmodule

// ==== source/reduction_lut.sv ====
/*
   Reduction tables
   One ROM per byte or top bit of every fold column, each entry holding
   chunk value times the chunk weight, reduced modulo the modulus
*/
module reduction_lut #(
   parameter logic [127:0] MODULUS = {1'b1, 126'd0, 1'b1}
) (
   input  logic          clk,
   input  logic          lut_read,
   input  sq_pkg::limb_t fold_columns [sq_pkg::FOLD_COLUMNS],
   output sq_pkg::word_t fold_words [3*sq_pkg::FOLD_COLUMNS][sq_pkg::NONREDUNDANT_LIMBS]
);
   import sq_pkg::*;

   localparam int NUM_TABLES = 3 * FOLD_COLUMNS;
   localparam int LUT_DEPTH  = 2**LOOKUP_WIDTH;
   localparam int RES_WIDTH  = WORD_LEN * NONREDUNDANT_LIMBS;
   localparam int SRC_WIDTH  = 3 * LOOKUP_WIDTH;

   // 2^shift mod MODULUS by repeated doubling
   function automatic logic [RES_WIDTH-1:0] pow2_mod(input int shift);
      logic [RES_WIDTH:0] r;
      r = (RES_WIDTH + 1)'(1);
      for (int i = 0; i < shift; i++) begin
         r = r << 1;
         if (r >= {1'b0, MODULUS}) begin
            r = r - {1'b0, MODULUS};
         end
      end
      return r[RES_WIDTH-1:0];
   endfunction

   for (genvar n = 0; n < NUM_TABLES; n++) begin : table_gen
      // Table n covers chunk n%3 (low byte, high byte, bit 16) of fold column n/3
      localparam int SHIFT = WORD_LEN * (NONREDUNDANT_LIMBS + n / 3) + LOOKUP_WIDTH * (n % 3);
      localparam logic [RES_WIDTH-1:0] STEP = pow2_mod(SHIFT);

      logic [RES_WIDTH-1:0]    rom [LUT_DEPTH];
      logic [RES_WIDTH-1:0]    rd_data;
      logic [SRC_WIDTH-1:0]    chunk_src;
      logic [LOOKUP_WIDTH-1:0] addr;

      initial begin : fill
         logic [RES_WIDTH:0] acc;
         acc = '0;
         for (int v = 0; v < LUT_DEPTH; v++) begin
            rom[v] = acc[RES_WIDTH-1:0];
            acc    = acc + {1'b0, STEP};
            if (acc >= {1'b0, MODULUS}) begin
               acc = acc - {1'b0, MODULUS};
            end
         end
      end

      assign chunk_src = {{(SRC_WIDTH - BIT_LEN){1'b0}}, fold_columns[n / 3]};
      assign addr      = chunk_src[LOOKUP_WIDTH * (n % 3) +: LOOKUP_WIDTH];

      always_ff @(posedge clk) begin
         if (lut_read) begin
            rd_data <= rom[addr];
         end
      end

      for (genvar w = 0; w < NONREDUNDANT_LIMBS; w++) begin : word_gen
         assign fold_words[n][w] = rd_data[WORD_LEN * w +: WORD_LEN];
      end
   end

endmodule

// ==== source/modular_fold.sv ====
/*
   Modular fold
   Adds the table words onto the low columns and registers the result
   limbs, with the top carry kept in the redundant limb
*/
module modular_fold (
   input  logic          clk,
   input  logic          fold_load,
   input  sq_pkg::limb_t low_columns [sq_pkg::NONREDUNDANT_LIMBS],
   input  sq_pkg::word_t fold_words [3*sq_pkg::FOLD_COLUMNS][sq_pkg::NONREDUNDANT_LIMBS],
   output sq_pkg::limb_t sq_out [sq_pkg::NUM_LIMBS]
);
   import sq_pkg::*;

   localparam int NUM_TABLES = 3 * FOLD_COLUMNS;

   limb_t   low_delay  [NONREDUNDANT_LIMBS];
   column_t limb_sum   [NONREDUNDANT_LIMBS];
   limb_t   next_limbs [NUM_LIMBS];

   // Low columns wait one cycle while the tables are read
   always_ff @(posedge clk) begin
      low_delay <= low_columns;
   end

   always_comb begin
      for (int k = 0; k < NONREDUNDANT_LIMBS; k++) begin
         limb_sum[k] = column_t'(low_delay[k]);
         for (int n = 0; n < NUM_TABLES; n++) begin
            limb_sum[k] += column_t'(fold_words[n][k]);
         end
      end
   end

   // Partial carry into the next limb
   always_comb begin
      next_limbs[0] = limb_t'(limb_sum[0][WORD_LEN-1:0]);
      for (int k = 1; k < NONREDUNDANT_LIMBS; k++) begin
         next_limbs[k] = limb_t'(limb_sum[k][WORD_LEN-1:0]) +
                         limb_t'(limb_sum[k-1][COL_LEN-1:WORD_LEN]);
      end
      // Redundant limb holds only the carry out of the top word
      next_limbs[NUM_LIMBS-1] =
         limb_t'(limb_sum[NONREDUNDANT_LIMBS-1][COL_LEN-1:WORD_LEN]);
   end

   always_ff @(posedge clk) begin
      if (fold_load) begin
         sq_out <= next_limbs;
      end
   end

endmodule

// ==== source/modular_squarer.sv ====
/*
   Iterated modular squarer
   Squares a redundant 9-limb operand modulo MODULUS the requested
   number of times, feeding each result back as the next input
*/
module modular_squarer #(
   parameter logic [127:0] MODULUS = 128'hd4a5_3c9e_81f0_6b27_e93d_15c8_a07f_4b63
) (
   input  logic                clk,
   input  logic                reset,
   input  logic                start,
   input  sq_pkg::limb_t       sq_in [sq_pkg::NUM_LIMBS],
   input  sq_pkg::iter_count_t iterations,
   output sq_pkg::limb_t       sq_out [sq_pkg::NUM_LIMBS],
   output logic                valid,
   output logic                busy
);
   import sq_pkg::*;

   limb_t     operand_reg  [NUM_LIMBS];
   limb_t     cur_operand  [NUM_LIMBS];
   mul_pair_t mul0_pair;
   mul_pair_t mul1_pair;
   logic      ab_capture;
   logic      bb_capture;
   logic      lut_read;
   logic      fold_load;
   logic      loop_select;
   column_t   product0     [2*SEG_HIGH_LIMBS];
   column_t   product1     [2*SEG_HIGH_LIMBS];
   limb_t     low_columns  [NONREDUNDANT_LIMBS];
   limb_t     fold_columns [FOLD_COLUMNS];
   word_t     fold_words   [3*FOLD_COLUMNS][NONREDUNDANT_LIMBS];

   // Operand is taken only when a new run is accepted
   always_ff @(posedge clk) begin
      if (start && !busy) begin
         operand_reg <= sq_in;
      end
   end

   // First iteration squares the captured input, later ones the last result
   always_comb begin
      for (int k = 0; k < NUM_LIMBS; k++) begin
         cur_operand[k] = loop_select ? sq_out[k] : operand_reg[k];
      end
   end

   square_sequencer square_sequencer_inst (
      .clk         (clk),
      .reset       (reset),
      .start       (start),
      .iterations  (iterations),
      .mul0_pair   (mul0_pair),
      .mul1_pair   (mul1_pair),
      .ab_capture  (ab_capture),
      .bb_capture  (bb_capture),
      .lut_read    (lut_read),
      .fold_load   (fold_load),
      .loop_select (loop_select),
      .valid       (valid),
      .busy        (busy)
   );

   segment_multiplier mul0_inst (
      .clk     (clk),
      .pair    (mul0_pair),
      .operand (cur_operand),
      .product (product0)
   );

   segment_multiplier mul1_inst (
      .clk     (clk),
      .pair    (mul1_pair),
      .operand (cur_operand),
      .product (product1)
   );

   column_accumulator column_accumulator_inst (
      .clk          (clk),
      .product0     (product0),
      .product1     (product1),
      .ab_capture   (ab_capture),
      .bb_capture   (bb_capture),
      .low_columns  (low_columns),
      .fold_columns (fold_columns)
   );

   reduction_lut #(
      .MODULUS (MODULUS)
   ) reduction_lut_inst (
      .clk          (clk),
      .lut_read     (lut_read),
      .fold_columns (fold_columns),
      .fold_words   (fold_words)
   );

   modular_fold modular_fold_inst (
      .clk         (clk),
      .fold_load   (fold_load),
      .low_columns (low_columns),
      .fold_words  (fold_words),
      .sq_out      (sq_out)
   );

endmodule

// ==== testbench/modular_squarer_props.sv ====
/*
   Handshake properties of the modular squarer
   Bound into the DUT, checks valid and busy on every clock edge
*/
module modular_squarer_props (
   input logic clk,
   input logic reset,
   input logic valid,
   input logic busy
);
   timeunit 1ns;
   timeprecision 1ps;

   // A result is announced for one cycle only
   valid_one_cycle: assert property (
      @(posedge clk) disable iff (reset) valid |=> !valid
   ) else $error("valid stayed high for two cycles");

   // Busy drops right after the valid cycle and at no other time
   busy_falls_after_valid: assert property (
      @(posedge clk) disable iff (reset) $fell(busy) |-> $past(valid)
   ) else $error("busy fell without a valid in the cycle before");

   // Held reset keeps the handshake quiet
   quiet_in_reset: assert property (
      @(posedge clk) (reset && $past(reset)) |-> (!valid && !busy)
   ) else $error("valid or busy high during reset");

endmodule

// ==== testbench/modular_squarer_tb.sv ====
/*
   Testbench of the iterated modular squarer
   Runs the tests of the stim file and checks latency, residue and handshake
*/
module modular_squarer_tb;
   timeunit 1ns;
   timeprecision 1ps;

   import sq_pkg::*;

   localparam logic [127:0] MODULUS = 128'hd4a5_3c9e_81f0_6b27_e93d_15c8_a07f_4b63;

   logic        clk = 1'b0;
   logic        reset;
   logic        start;
   limb_t       sq_in  [NUM_LIMBS];
   iter_count_t iterations;
   limb_t       sq_out [NUM_LIMBS];
   logic        valid;
   logic        busy;

   logic [127:0] stim_value    [$];
   iter_count_t  stim_iter     [$];
   logic [127:0] stim_expected [$];
   limb_t        last_out [NUM_LIMBS];
   logic [31:0]  lfsr_state = 32'hda9d1b78;
   int           value_errors = 0;
   int           protocol_errors = 0;
   int           cycle_count = 0;
   int           cycle_limit = 0;

   modular_squarer #(
      .MODULUS (MODULUS)
   ) modular_squarer_inst (
      .clk        (clk),
      .reset      (reset),
      .start      (start),
      .sq_in      (sq_in),
      .iterations (iterations),
      .sq_out     (sq_out),
      .valid      (valid),
      .busy       (busy)
   );

   bind modular_squarer modular_squarer_props modular_squarer_props_inst (
      .clk   (clk),
      .reset (reset),
      .valid (valid),
      .busy  (busy)
   );

   always #20 clk = ~clk;

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
         $display("Timeout after %0d cycles, the DUT stopped answering", cycle_count);
         $display("Verification failed");
         $finish;
      end
   end

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   // Weighted limb sum reduced mod M one bit at a time
   function automatic logic [127:0] residue_of(input limb_t limbs [NUM_LIMBS]);
      logic [159:0] weighted;
      logic [128:0] r;
      weighted = '0;
      for (int k = 0; k < NUM_LIMBS; k++) begin
         weighted = weighted + ({143'd0, limbs[k]} << (WORD_LEN * k));
      end
      r = '0;
      for (int i = 159; i >= 0; i--) begin
         r = {r[127:0], weighted[i]};
         if (r >= {1'b0, MODULUS}) begin
            r = r - {1'b0, MODULUS};
         end
      end
      return r[127:0];
   endfunction

   task automatic check_limb(input string name, input limb_t got, input limb_t expected);
      if (got !== expected) begin
         $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, expected);
         value_errors++;
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic expected);
      if (got !== expected) begin
         $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, expected);
         value_errors++;
      end
   endtask

   task automatic check_residue(input string name, input limb_t got [NUM_LIMBS],
                                input logic [127:0] expected);
      logic [127:0] r;
      r = residue_of(got);
      if (r !== expected) begin
         $display("Fail %s: got 0x%032h, expected 0x%032h", name, r, expected);
         value_errors++;
      end
   endtask

   task automatic run_test(input int t);
      int   idle;
      int   cycles;
      int   expected_cycles;
      logic inject;
      logic seen;
      idle = 0;
      for (int b = 0; b < 2; b++) begin
         lfsr_state = lfsr_next(lfsr_state);
         idle = (idle << 1) | int'(lfsr_state[0]);
      end
      expected_cycles = 5 * int'(stim_iter[t]);
      inject = (t % 2) == 1;

      // Result of the previous run must hold until the next start is taken
      repeat (idle) begin
         @(posedge clk);
         @(negedge clk);
         for (int k = 0; k < NUM_LIMBS && t > 0; k++) begin
            check_limb($sformatf("sq_out[%0d]", k), sq_out[k], last_out[k]);
         end
      end
      @(posedge clk);
      start      <= 1'b1;
      iterations <= stim_iter[t];
      for (int k = 0; k < NONREDUNDANT_LIMBS; k++) begin
         sq_in[k] <= {1'b0, stim_value[t][WORD_LEN*k +: WORD_LEN]};
      end
      sq_in[NUM_LIMBS-1] <= '0;
      @(negedge clk);
      for (int k = 0; k < NUM_LIMBS && t > 0; k++) begin
         check_limb($sformatf("sq_out[%0d]", k), sq_out[k], last_out[k]);
      end
      @(posedge clk);
      start <= 1'b0;

      cycles = 0;
      seen   = 1'b0;
      while (!seen && cycles <= expected_cycles + 5) begin
         @(posedge clk);
         cycles++;
         // A second start during the run must not disturb it
         if (inject && cycles == 2) begin
            start      <= 1'b1;
            iterations <= iter_count_t'(1);
            for (int k = 0; k < NUM_LIMBS; k++) begin
               sq_in[k] <= '1;
            end
         end else if (inject && cycles == 3) begin
            start <= 1'b0;
         end
         @(negedge clk);
         seen = valid;
         // Busy covers the whole run up to and including the valid cycle
         check_flag("busy", busy, 1'b1);
      end

      if (!seen) begin
         $display("Test %0d: valid never came within %0d cycles", t, cycles);
         protocol_errors++;
      end else begin
         if (cycles != expected_cycles) begin
            $display("Test %0d: valid came after %0d cycles instead of %0d",
                     t, cycles, expected_cycles);
            protocol_errors++;
         end
         check_residue("sq_out", sq_out, stim_expected[t]);
         for (int k = 0; k < NUM_LIMBS; k++) begin
            if ($isunknown(sq_out[k])) begin
               $display("Test %0d: sq_out limb %0d holds unknown bits", t, k);
               protocol_errors++;
            end
         end
         last_out = sq_out;
         @(posedge clk);
         @(negedge clk);
         check_flag("valid", valid, 1'b0);
         check_flag("busy", busy, 1'b0);
      end
   endtask

   initial begin : main
      int          fd;
      int          fields;
      string       line;
      logic [127:0] value;
      logic [31:0] count;
      logic [127:0] expected;
      reset      = 1'b1;
      start      = 1'b0;
      iterations = '0;
      for (int k = 0; k < NUM_LIMBS; k++) begin
         sq_in[k] = '0;
      end

      fd = $fopen("testbench/squarer_stim.txt", "r");
      if (fd == 0) begin
         $display("Could not open the stim file");
         protocol_errors++;
      end else begin
         while ($fgets(line, fd) > 0) begin
            fields = $sscanf(line, "%h %h %h", value, count, expected);
            if (fields == 3) begin
               stim_value.push_back(value);
               stim_iter.push_back(iter_count_t'(count));
               stim_expected.push_back(expected);
            end
         end
         $fclose(fd);
      end
      if (stim_value.size() == 0) begin
         $display("No tests were found in the stim file");
         protocol_errors++;
      end

      cycle_limit = 2;
      for (int i = 0; i < stim_iter.size(); i++) begin
         cycle_limit += 5 * int'(stim_iter[i]) + 10;
      end

      repeat (2) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      check_flag("valid", valid, 1'b0);
      check_flag("busy", busy, 1'b0);

      for (int t = 0; t < stim_value.size(); t++) begin
         run_test(t);
      end

      $display("Summary: %0d value errors, %0d protocol errors, %0d tests",
               value_errors, protocol_errors, stim_value.size());
      if (value_errors == 0 && protocol_errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// ==== testbench/squarer_stim.txt ====
// input_value iterations expected_residue, all in hex
// expected_residue is input^(2^iterations) mod M
00000000000000000000000000000001 01 00000000000000000000000000000001
00000000000000000000000000000002 01 00000000000000000000000000000004
00000000000000000000000000000003 04 0000000000000000000000000290d741
0000000000000000000000000000ffff 01 000000000000000000000000fffe0001
0000000000000000000000000000ffff 02 0000000000000000fffc0005fffc0001
0000000000000000000000000000ffff 03 2b52c37d7dd7951e168aea535f78b49e
00000000000000010000000000000000 01 2b5ac3617e0f94d816c2ea375f80b49d
00000000000000000000000000010000 03 2b5ac3617e0f94d816c2ea375f80b49d
00000000000000000000000000000002 07 2b5ac3617e0f94d816c2ea375f80b49d
00000000000000000000000000000002 06 00000000000000010000000000000000
d4a53c9e81f06b27e93d15c8a07f4b62 01 00000000000000000000000000000001
d4a53c9e81f06b27e93d15c8a07f4b65 05 00000000000000000000000100000000
d4a53c9e81f06b27e93d15c8a07f4b63 02 00000000000000000000000000000000
00000000000000000000000000000001 14 00000000000000000000000000000001

// ==== vlog.f ====
source/sq_pkg.sv
source/square_sequencer.sv
source/segment_multiplier.sv
source/column_accumulator.sv
source/reduction_lut.sv
source/modular_fold.sv
source/modular_squarer.sv
testbench/modular_squarer_props.sv
testbench/modular_squarer_tb.sv

// ==== Makefile ====
# Verilator build and run of the modular squarer testbench

TOP = modular_squarer_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   list these targets"

test:
	verilator --binary --assert -f vlog.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "^Verification passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
